// File: src.f
verilog/MemBackendPkg.sv
verilog/QueueIf.sv
verilog/RequestSorter.sv
verilog/CommandQueue.sv
verilog/CommandIssuer.sv
verilog/MemoryBackend.sv
testbench/MemoryBackendAsserts.sv
testbench/MemoryBackendTb.sv

// File: testbench/MemoryBackendTb.sv
module MemoryBackendTb;
    timeunit 1ns;
    timeprecision 1ps;
    import MemBackendPkg::*;

    // Requests sent over all tests
    localparam int TotalRequests = 10 + 10 + (12 + 3) + (12 + 10);

    logic       clk;
    logic       rst;
    logic       reqValid;
    logic       reqWrite;
    ReqId       reqId;
    MemAddr     reqAddr;
    MemData     reqData;
    logic       cmdValid;
    logic       cmdWrite;
    ReqId       cmdId;
    MemAddr     cmdAddr;
    MemData     cmdData;
    ChannelMode channelMode;

    // Expected lists come from the tests and observed lists from the monitor
    ReadEntry  expReads[$];
    WriteEntry expWrites[$];
    ReadEntry  obsReads[$];
    WriteEntry obsWrites[$];
    int        readCycles[$];
    int        writeCycles[$];
    int        readsChecked = 0;
    int        writesChecked = 0;
    logic [31:0] rngState = 32'hdc45_897d;
    ReqId      nextId = '0;

    MemoryBackend MemoryBackend_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------
    task automatic stopFail(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic valueFail(input string name, input logic [63:0] got, input logic [63:0] exp);
        stopFail($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic checkRead(input ReadEntry got, input ReadEntry exp);
        if (got.id != exp.id) valueFail("cmdId", got.id, exp.id);
        if (got.addr != exp.addr) valueFail("cmdAddr", got.addr, exp.addr);
    endtask

    task automatic checkWrite(input WriteEntry got, input WriteEntry exp);
        if (got.id != exp.id) valueFail("cmdId", got.id, exp.id);
        if (got.addr != exp.addr) valueFail("cmdAddr", got.addr, exp.addr);
        if (got.data != exp.data) valueFail("cmdData", got.data, exp.data);
    endtask

    task automatic checkMode(input ChannelMode got, input ChannelMode exp);
        if (got != exp) valueFail("channelMode", got, exp);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    // One request strobe sampled at the next edge
    task automatic sendRequest(input logic write);
        WriteEntry entry;
        rngState = xorshift(rngState);
        entry.id = nextId;
        entry.addr = rngState[AddrWidth-1:0];
        rngState = xorshift(rngState);
        // Random data on reads must never reach cmdData
        entry.data = rngState;
        nextId++;
        @(posedge clk);
        #2;
        reqValid = 1'b1;
        reqWrite = write;
        reqId = entry.id;
        reqAddr = entry.addr;
        reqData = entry.data;
        if (write) expWrites.push_back(entry);
        else expReads.push_back('{id: entry.id, addr: entry.addr});
    endtask

    task automatic sendBurst(input logic write, input int count);
        repeat (count) sendRequest(write);
    endtask

    task automatic endRequests;
        @(posedge clk);
        #2;
        reqValid = 1'b0;
    endtask

    // Wait for every expected command and compare in arrival order
    task automatic waitDrain;
        int limit;
        limit = (expReads.size() - obsReads.size() + expWrites.size() - obsWrites.size())
                * (CmdGap + TurnGap) + 50;
        while (obsReads.size() < expReads.size() || obsWrites.size() < expWrites.size()) begin
            if (limit == 0) stopFail("Missing command: queued requests were never issued");
            limit--;
            @(posedge clk);
        end
        // Idle tail catches stray commands
        repeat (2 * TurnGap) @(posedge clk);
        if (obsReads.size() != expReads.size() || obsWrites.size() != expWrites.size())
            stopFail("Unexpected extra command on the output");
        while (readsChecked < obsReads.size()) begin
            checkRead(obsReads[readsChecked], expReads[readsChecked]);
            readsChecked++;
        end
        while (writesChecked < obsWrites.size()) begin
            checkWrite(obsWrites[writesChecked], expWrites[writesChecked]);
            writesChecked++;
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic idleAfterReset;
        repeat (20) begin
            @(negedge clk);
            if (cmdValid) stopFail("cmdValid raised before any request");
            checkMode(channelMode, ModeRead);
        end
    endtask

    task automatic readsOnly;
        sendBurst(1'b0, 10);
        endRequests();
        waitDrain();
    endtask

    task automatic writesOnly;
        sendBurst(1'b1, 10);
        endRequests();
        waitDrain();
    endtask

    task automatic readPriority;
        int writeBase;
        writeBase = expWrites.size();
        sendBurst(1'b0, 12);
        sendBurst(1'b1, 3);
        endRequests();
        waitDrain();
        if (writeCycles[writeBase] < readCycles[$])
            stopFail("Read priority broken: a write issued while reads were queued");
    endtask

    task automatic writeHighMark;
        int writeBase;
        writeBase = expWrites.size();
        sendBurst(1'b0, 12);
        sendBurst(1'b1, 10);
        endRequests();
        waitDrain();
        if (writeCycles[writeBase] > readCycles[$])
            stopFail("Write high mark ignored: no write passed the waiting reads");
    endtask

    // ------------------------------------------------------------
    // Monitor samples on the falling edge
    // ------------------------------------------------------------
    initial begin
        int   cycle;
        int   lastCycle;
        logic lastWrite;
        cycle = 0;
        lastCycle = -1000;
        lastWrite = 1'b0;
        forever begin
            @(negedge clk);
            cycle++;
            if (rst && cmdValid) begin
                // Same kind needs CmdGap and a kind change needs TurnGap
                if (cycle - lastCycle < ((cmdWrite == lastWrite) ? CmdGap : TurnGap))
                    stopFail($sformatf("Spacing violation: only %0d cycles between commands",
                                       cycle - lastCycle));
                checkMode(channelMode, cmdWrite ? ModeWrite : ModeRead);
                if (cmdWrite) begin
                    obsWrites.push_back('{id: cmdId, addr: cmdAddr, data: cmdData});
                    writeCycles.push_back(cycle);
                end else begin
                    if (cmdData != '0) valueFail("cmdData", cmdData, '0);
                    obsReads.push_back('{id: cmdId, addr: cmdAddr});
                    readCycles.push_back(cycle);
                end
                lastCycle = cycle;
                lastWrite = cmdWrite;
            end
        end
    end

    // Stop at the first failing queue assertion
    initial begin
        wait (MemoryBackend_inst.readQueueInst.queueChecks.failures +
              MemoryBackend_inst.writeQueueInst.queueChecks.failures != 0);
        stopFail("Command queue assertion failed during the run");
    end

    // Watchdog sized from the worst case spacing per request
    initial begin
        repeat (TotalRequests * (CmdGap + TurnGap) + 200) @(posedge clk);
        stopFail("Watchdog expired: the DUT hangs");
    end

    initial begin
        rst = 1'b0;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqId = '0;
        reqAddr = '0;
        reqData = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b1;
        idleAfterReset();
        readsOnly();
        writesOnly();
        readPriority();
        writeHighMark();
        if (MemoryBackend_inst.readQueueInst.queueChecks.failures +
            MemoryBackend_inst.writeQueueInst.queueChecks.failures != 0) begin
            stopFail("Command queue assertion failed during the run");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: testbench/MemoryBackendAsserts.sv
module MemoryBackendAsserts (
    input logic                     clk,
    input logic                     rst,
    input logic                     push,
    input logic                     pop,
    input MemBackendPkg::QueueCount count
);
    timeunit 1ns;
    timeprecision 1ps;
    import MemBackendPkg::*;

    // Number of assertion failures in this queue
    int failures = 0;

    // ------------------------------------------------------------
    // Queue bounds
    // ------------------------------------------------------------
    // No push into a full queue
    pushNotFull: assert property (@(posedge clk) disable iff (!rst)
        push |-> count != QueueCount'(QueueDepth))
        else begin
            failures++;
            $error("push into a full command queue");
        end

    // No pop from an empty queue
    popNotEmpty: assert property (@(posedge clk) disable iff (!rst)
        pop |-> count != '0)
        else begin
            failures++;
            $error("pop from an empty command queue");
        end

endmodule

bind CommandQueue MemoryBackendAsserts queueChecks (
    .clk   (clk),
    .rst   (rst),
    .push  (queueSide.push),
    .pop   (queueSide.pop),
    .count (queueSide.count)
);

// File: verilog/MemoryBackend.sv
module MemoryBackend (
    input  logic                      clk,
    input  logic                      rst,
    // Front-end request strobe and fields
    input  logic                      reqValid,
    input  logic                      reqWrite,
    input  MemBackendPkg::ReqId       reqId,
    input  MemBackendPkg::MemAddr     reqAddr,
    input  MemBackendPkg::MemData     reqData,
    // Command output
    output logic                      cmdValid,
    output logic                      cmdWrite,
    output MemBackendPkg::ReqId       cmdId,
    output MemBackendPkg::MemAddr     cmdAddr,
    output MemBackendPkg::MemData     cmdData,
    output MemBackendPkg::ChannelMode channelMode
);
    import MemBackendPkg::*;

    // ------------------------------------------------------------
    // Queue links, one per command kind
    // ------------------------------------------------------------
    QueueIf #(.Entry(ReadEntry))  readLink ();
    QueueIf #(.Entry(WriteEntry)) writeLink ();

    // Sorts strobed requests by kind
    RequestSorter sorterInst (
        .clk        (clk),
        .rst        (rst),
        .reqValid   (reqValid),
        .reqWrite   (reqWrite),
        .reqId      (reqId),
        .reqAddr    (reqAddr),
        .reqData    (reqData),
        .readQueue  (readLink.producer),
        .writeQueue (writeLink.producer)
    );

    CommandQueue #(.Entry(ReadEntry)) readQueueInst (
        .clk       (clk),
        .rst       (rst),
        .queueSide (readLink.queue)
    );

    CommandQueue #(.Entry(WriteEntry)) writeQueueInst (
        .clk       (clk),
        .rst       (rst),
        .queueSide (writeLink.queue)
    );

    // Mode policy, spacing and command register
    CommandIssuer issuerInst (
        .clk         (clk),
        .rst         (rst),
        .readQueue   (readLink.consumer),
        .writeQueue  (writeLink.consumer),
        .cmdValid    (cmdValid),
        .cmdWrite    (cmdWrite),
        .cmdId       (cmdId),
        .cmdAddr     (cmdAddr),
        .cmdData     (cmdData),
        .channelMode (channelMode)
    );

endmodule

// File: verilog/CommandIssuer.sv
module CommandIssuer (
    input  logic                      clk,
    input  logic                      rst,
    QueueIf.consumer                  readQueue,
    QueueIf.consumer                  writeQueue,
    output logic                      cmdValid,
    output logic                      cmdWrite,
    output MemBackendPkg::ReqId       cmdId,
    output MemBackendPkg::MemAddr     cmdAddr,
    output MemBackendPkg::MemData     cmdData,
    output MemBackendPkg::ChannelMode channelMode
);
    import MemBackendPkg::*;

    // Timer wide enough for the longer of the two gaps
    typedef logic [$clog2(TurnGap + 1)-1:0] GapCount;

    ChannelMode mode;
    GapCount    gapTimer;

    logic readsWaiting;
    logic writesWaiting;
    logic gapExpired;
    logic switchMode;
    logic issueRead;
    logic issueWrite;

    // ------------------------------------------------------------
    // Queue status
    // ------------------------------------------------------------
    assign readsWaiting  = readQueue.count != '0;
    assign writesWaiting = writeQueue.count != '0;
    assign gapExpired    = gapTimer == '0;

    // ------------------------------------------------------------
    // Mode change policy, reads have priority
    // ------------------------------------------------------------
    always_comb begin
        switchMode = 1'b0;
        if (mode == ModeRead) begin
            // Give way when reads are gone or writes pile up
            switchMode = writesWaiting &&
                         (!readsWaiting || writeQueue.count > WriteHighMark);
        end else begin
            // Back to reads once writes drain or fall to the low mark
            switchMode = readsWaiting &&
                         (!writesWaiting || writeQueue.count <= WriteLowMark);
        end
    end

    // Issue only from the current mode's queue and never on a switch cycle
    assign issueRead  = gapExpired && !switchMode && mode == ModeRead && readsWaiting;
    assign issueWrite = gapExpired && !switchMode && mode == ModeWrite && writesWaiting;

    // Pop removes the head at the same edge the command is registered
    assign readQueue.pop  = issueRead;
    assign writeQueue.pop = issueWrite;

    // ------------------------------------------------------------
    // Mode register and gap timer
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mode     <= ModeRead;
            gapTimer <= '0;
        end else if (switchMode) begin
            mode     <= (mode == ModeRead) ? ModeWrite : ModeRead;
            // Turnaround counts from the switch, which is after the last command
            gapTimer <= GapCount'(TurnGap);
        end else if (issueRead || issueWrite) begin
            gapTimer <= GapCount'(CmdGap);
        end else if (!gapExpired) begin
            gapTimer <= gapTimer - 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Command output
    // ------------------------------------------------------------
    // One-cycle strobe per popped entry
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cmdValid <= 1'b0;
        end else begin
            cmdValid <= issueRead || issueWrite;
        end
    end

    // Command fields held until the next issue
    always_ff @(posedge clk) begin
        if (issueRead) begin
            cmdWrite <= 1'b0;
            cmdId    <= readQueue.head.id;
            cmdAddr  <= readQueue.head.addr;
            // Reads carry no data
            cmdData  <= '0;
        end else if (issueWrite) begin
            cmdWrite <= 1'b1;
            cmdId    <= writeQueue.head.id;
            cmdAddr  <= writeQueue.head.addr;
            cmdData  <= writeQueue.head.data;
        end
    end

    assign channelMode = mode;

endmodule

// File: verilog/CommandQueue.sv
module CommandQueue #(
    parameter type Entry = logic
) (
    input logic   clk,
    input logic   rst,
    QueueIf.queue queueSide
);
    import MemBackendPkg::*;

    typedef logic [$clog2(QueueDepth)-1:0] QueuePtr;

    // Circular storage
    Entry storage [QueueDepth];

    QueuePtr   wrPtr;
    QueuePtr   rdPtr;
    QueueCount occupancy;

    // Advance a pointer with wrap at the last slot
    function automatic QueuePtr nextPtr(input QueuePtr ptr);
        QueuePtr result;
        if (ptr == QueuePtr'(QueueDepth - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    // ------------------------------------------------------------
    // Storage write
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (queueSide.push) begin
            storage[wrPtr] <= queueSide.pushEntry;
        end
    end

    // ------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            occupancy <= '0;
        end else begin
            if (queueSide.push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (queueSide.pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // Push and pop together leave the count as is
            case ({queueSide.push, queueSide.pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // Head straight from storage, valid whenever count is nonzero
    assign queueSide.head  = storage[rdPtr];
    assign queueSide.count = occupancy;

endmodule

// File: verilog/RequestSorter.sv
module RequestSorter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   reqValid,
    input  logic                   reqWrite,
    input  MemBackendPkg::ReqId    reqId,
    input  MemBackendPkg::MemAddr  reqAddr,
    input  MemBackendPkg::MemData  reqData,
    QueueIf.producer               readQueue,
    QueueIf.producer               writeQueue
);
    import MemBackendPkg::*;

    ReadEntry  readNext;
    WriteEntry writeNext;

    // Build both entry forms from the request fields
    always_comb begin
        readNext.id    = reqId;
        readNext.addr  = reqAddr;
        writeNext.id   = reqId;
        writeNext.addr = reqAddr;
        writeNext.data = reqData;
    end

    // ------------------------------------------------------------
    // Push strobes, one cycle after the request strobe
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            readQueue.push  <= 1'b0;
            writeQueue.push <= 1'b0;
        end else begin
            // Exactly one queue takes a strobed request
            readQueue.push  <= reqValid && !reqWrite;
            writeQueue.push <= reqValid && reqWrite;
        end
    end

    // Entry payload, only meaningful alongside its push strobe
    always_ff @(posedge clk) begin
        if (reqValid) begin
            readQueue.pushEntry  <= readNext;
            writeQueue.pushEntry <= writeNext;
        end
    end

endmodule

// File: verilog/QueueIf.sv
interface QueueIf #(
    parameter type Entry = logic
);
    import MemBackendPkg::*;

    // Producer side
    // Single-cycle strobe writes the entry at that edge
    logic push;
    Entry pushEntry;

    // Consumer side
    // Strobe removes the head at that edge
    logic pop;

    // Queue state seen by the consumer
    Entry      head;
    QueueCount count;

    modport producer (
        output push,
        output pushEntry
    );

    modport queue (
        input  push,
        input  pushEntry,
        input  pop,
        output head,
        output count
    );

    modport consumer (
        output pop,
        input  head,
        input  count
    );

endinterface

// File: verilog/MemBackendPkg.sv
package MemBackendPkg;

    // ------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------
    localparam int IdWidth   = 4;
    localparam int AddrWidth = 16;
    localparam int DataWidth = 32;

    // Command queue sizing, count must reach QueueDepth itself
    localparam int QueueDepth = 16;
    localparam int CountWidth = $clog2(QueueDepth + 1);

    // Channel mode thresholds on the write queue count
    localparam int WriteHighMark = 6;
    localparam int WriteLowMark  = 2;

    // Command spacing in clock cycles
    // Same kind back to back
    localparam int CmdGap  = 4;
    // Read to write or write to read turnaround
    localparam int TurnGap = 8;

    // ------------------------------------------------------------
    // Types
    // ------------------------------------------------------------
    typedef logic [IdWidth-1:0]    ReqId;
    typedef logic [AddrWidth-1:0]  MemAddr;
    typedef logic [DataWidth-1:0]  MemData;
    typedef logic [CountWidth-1:0] QueueCount;

    // Read command, 20 bits
    typedef struct packed {
        ReqId   id;
        MemAddr addr;
    } ReadEntry;

    // Write command carries its data along, 52 bits
    typedef struct packed {
        ReqId   id;
        MemAddr addr;
        MemData data;
    } WriteEntry;

    typedef enum logic {
        ModeRead  = 1'b0,
        ModeWrite = 1'b1
    } ChannelMode;

endpackage
